// ==== hw/dcache_align.sv ====
/*
 * L1 data cache data alignment
 * load extraction with sign/zero extension and store byte merge
 */
`timescale 1ns/1ps

module dcache_align
    import dcache_pkg::*;
(
    input  offset_t   offset_i,
    input  mem_size_e size_i,
    input  line_t     line_i,
    input  data_t     wdata_i,
    output data_t     load_data_o,
    output line_t     merged_line_o
);

    line_t      shifted;
    line_t      store_line;
    byte_mask_t base_mask;
    byte_mask_t byte_mask;

    ////////////////////////////////////////
    // load path
    assign shifted = line_i >> {offset_i, 3'b000};

    always_comb begin
        case (size_i)
            SIZE_B:  load_data_o = {{56{shifted[7]}}, shifted[7:0]};
            SIZE_H:  load_data_o = {{48{shifted[15]}}, shifted[15:0]};
            SIZE_W:  load_data_o = {{32{shifted[31]}}, shifted[31:0]};
            SIZE_BU: load_data_o = {56'b0, shifted[7:0]};
            SIZE_HU: load_data_o = {48'b0, shifted[15:0]};
            SIZE_WU: load_data_o = {32'b0, shifted[31:0]};
            default: load_data_o = shifted;
        endcase
    end

    ////////////////////////////////////////
    // store path
    always_comb begin
        case (size_i)
            SIZE_B, SIZE_BU: base_mask = 8'h01;
            SIZE_H, SIZE_HU: base_mask = 8'h03;
            SIZE_W, SIZE_WU: base_mask = 8'h0F;
            default:         base_mask = 8'hFF;
        endcase
    end

    assign byte_mask  = base_mask << offset_i;
    assign store_line = line_t'(wdata_i) << {offset_i, 3'b000};

    // take masked bytes from the store data
    always_comb begin
        for (int i = 0; i < LINE_BYTES; i++) begin
            merged_line_o[i*8 +: 8] = byte_mask[i] ? store_line[i*8 +: 8] : line_i[i*8 +: 8];
        end
    end

endmodule

// ==== hw/dcache_array.sv ====
/*
 * L1 data cache storage
 * tag, valid, dirty and line store with combinational hit compare
 */
`timescale 1ns/1ps

module dcache_array
    import dcache_pkg::*;
(
    input  logic           clk,
    input  logic           rstn,
    dcache_array_if.array  arr
);

    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;
    tag_t                 tag_mem [NUM_LINES];
    line_t                line_mem [NUM_LINES];

    ////////////////////////////////////////
    // lookup
    assign arr.hit          = valid_q[arr.index] && (tag_mem[arr.index] == arr.tag);
    assign arr.victim_dirty = valid_q[arr.index] && dirty_q[arr.index];
    assign arr.victim_tag   = tag_mem[arr.index];
    assign arr.rd_line      = line_mem[arr.index];

    ////////////////////////////////////////
    // line state flags
    always_ff @(posedge clk) begin
        if (rstn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (arr.fill) begin
            valid_q[arr.index] <= 1'b1;
            dirty_q[arr.index] <= 1'b0;
        end else if (arr.line_we && arr.dirty_set) begin
            dirty_q[arr.index] <= 1'b1;
        end
    end

    // tag and data store
    always_ff @(posedge clk) begin
        if (arr.fill || arr.line_we) begin
            line_mem[arr.index] <= arr.line_wdata;
        end
        if (arr.fill) begin
            tag_mem[arr.index] <= arr.tag;
        end
    end

    // refill only lands on a line that missed
    a_fill_on_miss: assert property (
        @(posedge clk) disable iff (rstn) arr.fill |-> !arr.hit
    );

    // store merge only into a resident line
    a_store_on_hit: assert property (
        @(posedge clk) disable iff (rstn) arr.line_we |-> arr.hit && !arr.fill
    );

endmodule

// ==== hw/dcache_bus_port.sv ====
/*
 * L1 data cache memory bus port
 * sequences two-beat line writeback and refill and buffers the refill words
 */
`timescale 1ns/1ps

module dcache_bus_port
    import dcache_pkg::*;
(
    input  logic           clk,
    input  logic           rstn,
    dcache_refill_if.port  rf,
    output logic           mem_cyc_o,
    output logic           mem_stb_o,
    output logic           mem_we_o,
    output addr_t          mem_adr_o,
    output word_t          mem_dat_o,
    input  word_t          mem_dat_i,
    input  logic           mem_ack_i
);

    logic  busy_q;
    logic  we_q;
    logic  beat_q;
    logic  done_q;
    logic  last_ack;
    line_t buf_q;

    assign last_ack = busy_q && mem_ack_i && (beat_q == 1'(BUS_BEATS - 1));

    ////////////////////////////////////////
    // transfer control and beat counter
    always_ff @(posedge clk) begin
        if (rstn) begin
            busy_q <= 1'b0;
            we_q   <= 1'b0;
            beat_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= last_ack;
            if (rf.start) begin
                busy_q <= 1'b1;
                we_q   <= rf.is_write;
                beat_q <= 1'b0;
            end else if (busy_q && mem_ack_i) begin
                beat_q <= ~beat_q;
                if (last_ack) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // refill buffer fills low word first
    always_ff @(posedge clk) begin
        if (busy_q && mem_ack_i && !we_q) begin
            if (beat_q) begin
                buf_q[63:32] <= mem_dat_i;
            end else begin
                buf_q[31:0] <= mem_dat_i;
            end
        end
    end

    assign rf.done    = done_q;
    assign rf.rd_line = buf_q;

    ////////////////////////////////////////
    // bus outputs
    assign mem_cyc_o = busy_q;
    assign mem_stb_o = busy_q;
    assign mem_we_o  = busy_q && we_q;
    assign mem_adr_o = {rf.line_addr[31:OFFSET_W], beat_q, 2'b00};
    assign mem_dat_o = beat_q ? rf.wr_line[63:32] : rf.wr_line[31:0];

    // address and write word hold until the beat is acknowledged
    a_hold_until_ack: assert property (
        @(posedge clk) disable iff (rstn)
        (mem_stb_o && !mem_ack_i) |=> $stable(mem_adr_o) && $stable(mem_dat_o)
    );

endmodule

// ==== hw/dcache_ctrl.sv ====
/*
 * L1 data cache controller
 * blocking request FSM for lookup, writeback, refill and replay
 */
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  logic            req_valid_i,
    output logic            req_ready_o,
    input  logic            req_store_i,
    input  addr_t           req_addr_i,
    input  mem_size_e       req_size_i,
    input  data_t           req_wdata_i,
    output logic            resp_valid_o,
    input  line_t           merged_line_i,
    output offset_t         req_offset_o,
    output mem_size_e       req_size_o,
    output data_t           req_wdata_o,
    dcache_array_if.ctrl    arr,
    dcache_refill_if.ctrl   rf
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        start_q;
    logic        start_d;
    logic        writeback;
    logic        store_q;
    addr_t       addr_q;
    mem_size_e   size_q;
    data_t       wdata_q;

    assign req_ready_o = (state_q == ST_IDLE);
    assign writeback   = (state_q == ST_WRITEBACK);

    always_ff @(posedge clk) begin
        if (rstn) begin
            state_q <= ST_IDLE;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= start_d;
        end
    end

    // accepted request
    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            store_q <= req_store_i;
            addr_q  <= req_addr_i;
            size_q  <= req_size_i;
            wdata_q <= req_wdata_i;
        end
    end

    assign req_offset_o = addr_q[OFFSET_W-1:0];
    assign req_size_o   = size_q;
    assign req_wdata_o  = wdata_q;

    ////////////////////////////////////////
    // array and bus port requests
    assign arr.index      = addr_q[OFFSET_W +: INDEX_W];
    assign arr.tag        = addr_q[OFFSET_W + INDEX_W +: TAG_W];
    assign arr.line_wdata = (state_q == ST_FILL) ? rf.rd_line : merged_line_i;

    assign rf.start     = start_q;
    assign rf.is_write  = writeback;
    assign rf.wr_line   = arr.rd_line;
    // victim address on writeback
    assign rf.line_addr = writeback ? {arr.victim_tag, arr.index, {OFFSET_W{1'b0}}}
                                    : {addr_q[31:OFFSET_W], {OFFSET_W{1'b0}}};

    ////////////////////////////////////////
    // next state
    always_comb begin
        state_d       = state_q;
        start_d       = 1'b0;
        resp_valid_o  = 1'b0;
        arr.line_we   = 1'b0;
        arr.dirty_set = 1'b0;
        arr.fill      = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (arr.hit) begin
                    resp_valid_o  = !store_q;
                    arr.line_we   = store_q;
                    arr.dirty_set = store_q;
                    state_d       = ST_IDLE;
                end else begin
                    start_d = 1'b1;
                    state_d = arr.victim_dirty ? ST_WRITEBACK : ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (rf.done) begin
                    start_d = 1'b1;
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (rf.done) begin
                    state_d = ST_FILL;
                end
            end
            ST_FILL: begin
                // install line, then replay the lookup
                arr.fill = 1'b1;
                state_d  = ST_LOOKUP;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    // replayed lookup after a fill must hit
    a_replay_hits: assert property (
        @(posedge clk) disable iff (rstn) (state_q == ST_FILL) |=> arr.hit
    );

endmodule

// ==== hw/dcache_ifs.sv ====
/*
 * L1 data cache internal interfaces
 * array access from the controller, and refill/writeback to the bus port
 */
`timescale 1ns/1ps

interface dcache_array_if
    import dcache_pkg::*;
();
    index_t index;
    tag_t   tag;
    logic   line_we;
    line_t  line_wdata;
    logic   dirty_set;
    logic   fill;
    logic   hit;
    logic   victim_dirty;
    tag_t   victim_tag;
    line_t  rd_line;

    modport ctrl (output index, tag, line_we, line_wdata, dirty_set, fill,
                  input  hit, victim_dirty, victim_tag, rd_line);
    modport array (input  index, tag, line_we, line_wdata, dirty_set, fill,
                   output hit, victim_dirty, victim_tag, rd_line);
endinterface

interface dcache_refill_if
    import dcache_pkg::*;
();
    logic  start;
    logic  is_write;
    addr_t line_addr;
    line_t wr_line;
    logic  done;
    line_t rd_line;

    modport ctrl (output start, is_write, line_addr, wr_line,
                  input  done, rd_line);
    modport port (input  start, is_write, line_addr, wr_line,
                  output done, rd_line);
endinterface

// ==== hw/dcache_pkg.sv ====
/*
 * L1 data cache shared definitions
 * geometry, vector types and the size and state encodings
 */
package dcache_pkg;

    ////////////////////////////////////////
    // geometry
    localparam int NUM_LINES  = 16;
    localparam int LINE_BYTES = 8;
    localparam int OFFSET_W   = 3;
    localparam int INDEX_W    = 4;
    localparam int TAG_W      = 25;
    localparam int BUS_BEATS  = 2;

    ////////////////////////////////////////
    // vector types
    typedef logic [31:0]               addr_t;
    typedef logic [63:0]               data_t;
    typedef logic [LINE_BYTES*8-1:0]   line_t;
    typedef logic [31:0]               word_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [OFFSET_W-1:0]       offset_t;
    typedef logic [LINE_BYTES-1:0]     byte_mask_t;

    // load/store size code, upper bit means zero extension
    typedef enum logic [2:0] {
        SIZE_B  = 3'd0,
        SIZE_H  = 3'd1,
        SIZE_W  = 3'd2,
        SIZE_D  = 3'd3,
        SIZE_BU = 3'd4,
        SIZE_HU = 3'd5,
        SIZE_WU = 3'd6
    } mem_size_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_FILL
    } ctrl_state_e;

endpackage

// ==== hw/dcache_top.sv ====
/*
 * L1 data cache top level
 * blocking direct-mapped write-back cache with a 32-bit refill bus
 */
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    // request
    input  logic      req_valid_i,
    output logic      req_ready_o,
    input  logic      req_store_i,
    input  addr_t     req_addr_i,
    input  mem_size_e req_size_i,
    input  data_t     req_wdata_i,
    // response
    output logic      resp_valid_o,
    output data_t     resp_data_o,
    // memory bus
    output logic      mem_cyc_o,
    output logic      mem_stb_o,
    output logic      mem_we_o,
    output addr_t     mem_adr_o,
    output word_t     mem_dat_o,
    input  word_t     mem_dat_i,
    input  logic      mem_ack_i
);

    line_t     merged_line;
    offset_t   req_offset;
    mem_size_e req_size;
    data_t     req_wdata;

    dcache_array_if  arr_if ();
    dcache_refill_if rf_if ();

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_store_i   (req_store_i),
        .req_addr_i    (req_addr_i),
        .req_size_i    (req_size_i),
        .req_wdata_i   (req_wdata_i),
        .resp_valid_o  (resp_valid_o),
        .merged_line_i (merged_line),
        .req_offset_o  (req_offset),
        .req_size_o    (req_size),
        .req_wdata_o   (req_wdata),
        .arr           (arr_if.ctrl),
        .rf            (rf_if.ctrl)
    );

    dcache_array u_array (
        .clk  (clk),
        .rstn (rstn),
        .arr  (arr_if.array)
    );

    dcache_align u_align (
        .offset_i      (req_offset),
        .size_i        (req_size),
        .line_i        (arr_if.rd_line),
        .wdata_i       (req_wdata),
        .load_data_o   (resp_data_o),
        .merged_line_o (merged_line)
    );

    dcache_bus_port u_bus_port (
        .clk       (clk),
        .rstn      (rstn),
        .rf        (rf_if.port),
        .mem_cyc_o (mem_cyc_o),
        .mem_stb_o (mem_stb_o),
        .mem_we_o  (mem_we_o),
        .mem_adr_o (mem_adr_o),
        .mem_dat_o (mem_dat_o),
        .mem_dat_i (mem_dat_i),
        .mem_ack_i (mem_ack_i)
    );

endmodule

// ==== l1dcache.f ====
+incdir+verif
hw/dcache_pkg.sv
hw/dcache_ifs.sv
hw/dcache_array.sv
hw/dcache_align.sv
hw/dcache_bus_port.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
verif/dcache_tb.sv

// ==== verif/dcache_tb_vectors.svh ====
/*
 * L1 data cache request table
 * columns are name, store flag, address, size code and store data
 */
task automatic build_table();
    add_row("cold_ld_d",   1'b0, 32'h0000_0100, SIZE_D,  64'h0);
    add_row("ld_b",        1'b0, 32'h0000_0100, SIZE_B,  64'h0);
    add_row("ld_bu",       1'b0, 32'h0000_0101, SIZE_BU, 64'h0);
    add_row("ld_h",        1'b0, 32'h0000_0102, SIZE_H,  64'h0);
    add_row("ld_hu",       1'b0, 32'h0000_0106, SIZE_HU, 64'h0);
    add_row("ld_w",        1'b0, 32'h0000_0104, SIZE_W,  64'h0);
    add_row("ld_wu",       1'b0, 32'h0000_0100, SIZE_WU, 64'h0);
    add_row("st_b",        1'b1, 32'h0000_0103, SIZE_B,  64'h0000_0000_0000_0080);
    add_row("ld_b_back",   1'b0, 32'h0000_0103, SIZE_B,  64'h0);
    add_row("st_h",        1'b1, 32'h0000_0106, SIZE_H,  64'h0000_0000_0000_8001);
    add_row("ld_hu_back",  1'b0, 32'h0000_0106, SIZE_HU, 64'h0);
    add_row("st_w",        1'b1, 32'h0000_0100, SIZE_W,  64'h0000_0000_dead_beef);
    add_row("ld_d_merged", 1'b0, 32'h0000_0100, SIZE_D,  64'h0);
    add_row("st_d_miss",   1'b1, 32'h0000_0108, SIZE_D,  64'h0123_4567_89ab_cdef);
    add_row("ld_w_hit",    1'b0, 32'h0000_010c, SIZE_W,  64'h0);
    add_row("st_d",        1'b1, 32'h0000_0108, SIZE_D,  64'h1122_3344_5566_7788);
    add_row("ld_d_back",   1'b0, 32'h0000_0108, SIZE_D,  64'h0);
    // same index as 0x100 so the dirty victim goes out first
    add_row("evict_ld_d",  1'b0, 32'h0000_0180, SIZE_D,  64'h0);
    add_row("reload_d",    1'b0, 32'h0000_0100, SIZE_D,  64'h0);
    add_row("evict_st_d",  1'b1, 32'h0000_0888, SIZE_D,  64'hfedc_ba98_7654_3210);
    add_row("reload_wu",   1'b0, 32'h0000_010c, SIZE_WU, 64'h0);
    add_row("reload_b",    1'b0, 32'h0000_088f, SIZE_B,  64'h0);
endtask

// ==== verif/dcache_tb.sv ====
/*
 * L1 data cache testbench
 * table-driven requests against a shadow memory and a tag model
 */
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    logic      clk;
    logic      rstn;
    logic      req_valid;
    logic      req_ready;
    logic      req_store;
    addr_t     req_addr;
    mem_size_e req_size;
    data_t     req_wdata;
    logic      resp_valid;
    data_t     resp_data;
    logic      mem_cyc;
    logic      mem_stb;
    logic      mem_we;
    addr_t     mem_adr;
    word_t     mem_wdat;
    word_t     mem_rdat;
    logic      mem_ack;

    logic [7:0]  mem [4096];
    logic [7:0]  shadow [4096];
    logic [15:0] ref_valid;
    logic [15:0] ref_dirty;
    tag_t        ref_tag [16];
    logic [64:0] bus_log [$];
    logic [64:0] exp_log [$];

    string       row_name [$];
    logic        row_store [$];
    addr_t       row_addr [$];
    mem_size_e   row_size [$];
    data_t       row_wdata [$];

    logic [31:0] rng;
    int          ack_wait;
    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    int          timeout_cycles;
    logic        row_ok;

    dcache_top u_dcache_top (
        .clk          (clk),
        .rstn         (rstn),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .req_store_i  (req_store),
        .req_addr_i   (req_addr),
        .req_size_i   (req_size),
        .req_wdata_i  (req_wdata),
        .resp_valid_o (resp_valid),
        .resp_data_o  (resp_data),
        .mem_cyc_o    (mem_cyc),
        .mem_stb_o    (mem_stb),
        .mem_we_o     (mem_we),
        .mem_adr_o    (mem_adr),
        .mem_dat_o    (mem_wdat),
        .mem_dat_i    (mem_rdat),
        .mem_ack_i    (mem_ack)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int mem_idx(input addr_t a);
        return int'(a & 32'hfff);
    endfunction

    // every address bit of the 4 KB space shows up in the pattern
    function automatic logic [7:0] fill_byte(input int a);
        return a[7:0] ^ {4'h0, a[11:8]} ^ 8'ha5;
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        return {shadow[mem_idx(a + 3)], shadow[mem_idx(a + 2)],
                shadow[mem_idx(a + 1)], shadow[mem_idx(a)]};
    endfunction

    // little endian gather with sign extension for codes below 4
    function automatic data_t expected_load(input addr_t a, input mem_size_e sz);
        int    n;
        data_t v;
        n = 1 << sz[1:0];
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i*8 +: 8] = shadow[mem_idx(a + i)];
        end
        if (!sz[2] && n < 8 && v[n*8-1]) begin
            v = v | ~((64'd1 << (n * 8)) - 64'd1);
        end
        return v;
    endfunction

    task automatic store_shadow(input addr_t a, input mem_size_e sz, input data_t wd);
        for (int i = 0; i < (1 << sz[1:0]); i++) begin
            shadow[mem_idx(a + i)] = wd[i*8 +: 8];
        end
    endtask

    task automatic add_row(input string name, input logic st, input addr_t a,
                           input mem_size_e sz, input data_t wd);
        row_name.push_back(name);
        row_store.push_back(st);
        row_addr.push_back(a);
        row_size.push_back(sz);
        row_wdata.push_back(wd);
    endtask

    `include "dcache_tb_vectors.svh"

    task automatic report_error(input string name, input string msg);
        $display("FAILED %s: %s", name, msg);
        row_ok = 1'b0;
    endtask

    task automatic value_error(input string name, input string what,
                               input logic [64:0] exp, input logic [64:0] act);
        $display("FAILED %s %s expected %h actual %h", name, what, exp, act);
        row_ok = 1'b0;
    endtask

    task automatic finish_test(input string name);
        if (row_ok) begin
            pass_cnt++;
            $display("PASSED %s", name);
        end else begin
            fail_cnt++;
            $display("FAILED %s", name);
        end
    endtask

    ////////////////////////////////////////
    // memory model with a random ack delay per beat
    always @(negedge clk) begin
        mem_ack = 1'b0;
        if (mem_stb && !mem_cyc) begin
            report_error("bus", "strobe raised outside a bus cycle");
        end
        if (mem_cyc && req_ready) begin
            report_error("bus", "bus cycle open while the cache accepts requests");
        end
        if (mem_stb) begin
            if (ack_wait == 0) begin
                mem_ack = 1'b1;
                for (int i = 0; i < 4; i++) begin
                    if (mem_we) begin
                        mem[mem_idx(mem_adr + i)] = mem_wdat[i*8 +: 8];
                    end else begin
                        mem_rdat[i*8 +: 8] = mem[mem_idx(mem_adr + i)];
                    end
                end
                bus_log.push_back({mem_we, mem_adr, mem_we ? mem_wdat : 32'h0});
                rng = xorshift(rng);
                ack_wait = int'(rng[1:0]);
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    ////////////////////////////////////////
    // predict, drive, wait and check one request
    task automatic run_row(input int r);
        string     name;
        addr_t     a;
        index_t    idx;
        tag_t      tag;
        logic      hit;
        logic      st;
        mem_size_e sz;
        data_t     exp_val;
        int        cycles;
        logic      done;
        name = row_name[r];
        a    = row_addr[r];
        st   = row_store[r];
        sz   = row_size[r];
        idx  = a[6:3];
        tag  = a[31:7];
        hit  = ref_valid[idx] && (ref_tag[idx] == tag);
        exp_val = '0;
        row_ok  = 1'b1;
        exp_log.delete();
        if (!hit) begin
            if (ref_valid[idx] && ref_dirty[idx]) begin
                exp_log.push_back({1'b1, ref_tag[idx], idx, 3'b000,
                                   shadow_word({ref_tag[idx], idx, 3'b000})});
                exp_log.push_back({1'b1, ref_tag[idx], idx, 3'b100,
                                   shadow_word({ref_tag[idx], idx, 3'b100})});
            end
            exp_log.push_back({1'b0, a[31:3], 3'b000, 32'h0});
            exp_log.push_back({1'b0, a[31:3], 3'b100, 32'h0});
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tag;
            ref_dirty[idx] = 1'b0;
        end
        if (st) begin
            store_shadow(a, sz, row_wdata[r]);
            ref_dirty[idx] = 1'b1;
        end else begin
            exp_val = expected_load(a, sz);
        end

        while (!req_ready) @(negedge clk);
        bus_log.delete();
        req_valid = 1'b1;
        req_store = st;
        req_addr  = a;
        req_size  = sz;
        req_wdata = row_wdata[r];
        @(negedge clk);
        req_valid = 1'b0;
        cycles = 1;
        done   = 1'b0;
        while (!done) begin
            if (st && resp_valid) begin
                report_error(name, "store produced a response");
            end
            if (st ? req_ready : resp_valid) begin
                done = 1'b1;
            end else if (req_ready) begin
                report_error(name, "ready came back before the load response");
                done = 1'b1;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end

        if (hit && cycles != (st ? 2 : 1)) begin
            report_error(name, $sformatf("hit took %0d cycles", cycles));
        end
        if (!st && resp_valid) begin
            if (resp_data !== exp_val) begin
                value_error(name, "load data", {1'b0, exp_val}, {1'b0, resp_data});
            end
            @(negedge clk);
            if (resp_valid) begin
                report_error(name, "response lasted more than one cycle");
            end
        end
        if (bus_log.size() != exp_log.size()) begin
            report_error(name, $sformatf("expected %0d bus beats but saw %0d",
                                         exp_log.size(), bus_log.size()));
        end else begin
            foreach (exp_log[i]) begin
                if (bus_log[i] !== exp_log[i]) begin
                    value_error(name, $sformatf("bus beat %0d", i), exp_log[i], bus_log[i]);
                end
            end
        end
        finish_test(name);
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b1;
        req_valid = 1'b0;
        req_store = 1'b0;
        req_addr  = '0;
        req_size  = SIZE_D;
        req_wdata = '0;
        mem_rdat  = '0;
        mem_ack   = 1'b0;
        rng       = 32'd6459;
        ack_wait  = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        ref_valid = '0;
        ref_dirty = '0;
        for (int a = 0; a < 4096; a++) begin
            mem[a]    = fill_byte(a);
            shadow[a] = fill_byte(a);
        end
        build_table();
        timeout_cycles = row_name.size() * 60;

        repeat (4) @(negedge clk);
        rstn = 1'b0;
        @(negedge clk);
        row_ok = 1'b1;
        if (req_ready !== 1'b1 || resp_valid !== 1'b0 || mem_cyc !== 1'b0
            || mem_stb !== 1'b0 || mem_we !== 1'b0) begin
            report_error("reset", "outputs not in their idle state after reset");
        end
        finish_test("reset");

        for (int r = 0; r < row_name.size(); r++) begin
            run_row(r);
        end

        $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // run limit
    initial begin
        cycle_cnt = 0;
        @(posedge clk);
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
